// File: hdl/cdp_pkg.sv
// cross-channel normalization datapath
// widths, types and shared constants for all stages

package cdp_pkg;

  //////////////////////////////////////////////////
  // datapath widths
  typedef logic signed [7:0]  data_t;   // channel value in, converted and out
  typedef logic        [15:0] sq_t;     // square of one converted value
  typedef logic        [19:0] sum_t;    // up to nine squares
  typedef logic        [15:0] coef_t;   // table coefficient, unsigned
  typedef logic signed [24:0] prod_t;   // value times scale or coefficient
  typedef logic        [31:0] acc_t;    // output offset and perf counters
  typedef logic        [1:0]  win_t;    // 0..3 -> 3,5,7,9 channels

  // config fields
  typedef logic signed [15:0] scale_t;  // input scale
  typedef logic        [4:0]  shift_t;  // right shift amounts
  typedef logic signed [39:0] wide_t;   // headroom before saturation

  localparam int HALF_WIN_MAX = 4;      // half of the 9-channel window

  localparam data_t DATA_MAX = 8'h7f;
  localparam data_t DATA_MIN = 8'h80;

  // sqsum: run takes input, flush drains the tail of a group
  typedef enum logic {
    RUN   = 1'b0,
    FLUSH = 1'b1
  } flush_state_e;

  //////////////////////////////////////////////////
  // clip a wide signed value into data_t range
  function automatic data_t sat_data(input wide_t v);
    data_t r;
    if (v > wide_t'(DATA_MAX)) begin
      r = DATA_MAX;
    end else if (v < wide_t'(DATA_MIN)) begin
      r = DATA_MIN;
    end else begin
      r = data_t'(v);  // in range, plain truncation
    end
    return r;
  endfunction

endpackage

// File: hdl/cdp_cvt_in.sv
// input converter
// (value - offset) * scale >>> shift, saturated to 8 bits, one register stage

`timescale 1ns/1ps

module cdp_cvt_in (
  input  logic            nvdla_core_clk,
  input  logic            nvdla_core_rstn,
  input  logic            in_valid,
  output logic            in_ready,
  input  cdp_pkg::data_t  in_data,
  input  logic            in_last,
  input  cdp_pkg::data_t  datin_offset,
  input  cdp_pkg::scale_t datin_scale,
  input  cdp_pkg::shift_t datin_shifter,
  output logic            cvt_valid,
  input  logic            cvt_ready,
  output cdp_pkg::data_t  cvt_data,
  output logic            cvt_last
);

logic signed [8:0] in_diff;   // one extra bit for the subtract
cdp_pkg::prod_t    in_prod;
cdp_pkg::prod_t    in_shift;
cdp_pkg::data_t    cvt_nxt;
logic              in_acc;

assign in_diff  = {in_data[7], in_data} - {datin_offset[7], datin_offset};
assign in_prod  = cdp_pkg::prod_t'(in_diff) * cdp_pkg::prod_t'(datin_scale);
assign in_shift = in_prod >>> datin_shifter;  // arithmetic shift keeps the sign
assign cvt_nxt  = cdp_pkg::sat_data(cdp_pkg::wide_t'(in_shift));

assign in_ready = !cvt_valid || cvt_ready;    // slot free or leaving
assign in_acc   = in_valid && in_ready;

always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
  if (!nvdla_core_rstn) begin
    cvt_valid <= 1'b0;
  end else if (in_acc) begin
    cvt_valid <= 1'b1;
  end else if (cvt_ready) begin
    cvt_valid <= 1'b0;
  end
end

always_ff @(posedge nvdla_core_clk) begin
  if (in_acc) begin
    cvt_data <= cvt_nxt;
    cvt_last <= in_last;  // group marker rides along
  end
end

// upstream holds a stalled value and its group marker
a_in_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
  (in_valid && !in_ready) |=> (in_valid && $stable(in_data) && $stable(in_last)));

endmodule

// File: hdl/cdp_sqsum.sv
// windowed cross-channel sum of squares
// centred window of 3..9 channels, clipped at group edges, flushed after last

`timescale 1ns/1ps

module cdp_sqsum (
  input  logic           nvdla_core_clk,
  input  logic           nvdla_core_rstn,
  input  logic           sq_in_valid,
  output logic           sq_in_ready,
  input  cdp_pkg::data_t cvt_data,
  input  logic           cvt_last,
  input  cdp_pkg::win_t  normalz_len,
  output logic           sum_valid,
  input  logic           sum_ready,
  output cdp_pkg::sum_t  sum_data,
  output logic           sum_last
);

localparam int WIN_MAX = 2 * cdp_pkg::HALF_WIN_MAX + 1;

cdp_pkg::flush_state_e state_q;
cdp_pkg::sq_t          sq_q   [WIN_MAX];  // slot 0 newest
cdp_pkg::sq_t          sq_nxt [WIN_MAX];
logic [WIN_MAX-1:0]    mask_q;            // slot holds a channel of this group
logic [WIN_MAX-1:0]    mask_nxt;
logic                  grp_start_q;       // next accept opens a group
logic [2:0]            flush_cnt_q;
logic [2:0]            half_win;
cdp_pkg::sq_t          sq_new;
cdp_pkg::sum_t         win_sum;
logic                  out_free;
logic                  in_acc;
logic                  flush_step;
logic                  flush_done;
logic                  shift_en;
logic                  emit;

assign half_win    = {1'b0, normalz_len} + 3'd1;   // 1..4
assign out_free    = !sum_valid || sum_ready;
assign sq_in_ready = (state_q == cdp_pkg::RUN) && out_free;
assign in_acc      = sq_in_valid && sq_in_ready;
assign flush_step  = (state_q == cdp_pkg::FLUSH) && out_free;
assign flush_done  = flush_step && (flush_cnt_q == 3'd1);
assign shift_en    = in_acc || flush_step;        // flush shifts in an empty slot
assign sq_new      = cdp_pkg::sq_t'(16'(cvt_data) * 16'(cvt_data));

//////////////////////////////////////////////////
// next window contents
always_comb begin
  sq_nxt[0]   = sq_new;
  mask_nxt[0] = in_acc;
  for (int i = 1; i < WIN_MAX; i++) begin
    sq_nxt[i]   = sq_q[i-1];
    mask_nxt[i] = mask_q[i-1] && !(in_acc && grp_start_q);  // drop older group
  end
end

// sum over slots 0..2h with the centre at slot h
always_comb begin
  win_sum = '0;
  for (int i = 0; i < WIN_MAX; i++) begin
    if (mask_nxt[i] && (i <= 2 * int'(half_win))) begin
      win_sum = win_sum + cdp_pkg::sum_t'(sq_nxt[i]);
    end
  end
end

assign emit = mask_nxt[half_win];  // centre channel present

//////////////////////////////////////////////////
// control
always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
  if (!nvdla_core_rstn) begin
    state_q     <= cdp_pkg::RUN;
    flush_cnt_q <= '0;
    grp_start_q <= 1'b1;
    mask_q      <= '0;
  end else begin
    if (shift_en) mask_q <= mask_nxt;
    if (in_acc) grp_start_q <= 1'b0;
    case (state_q)
      cdp_pkg::RUN: begin
        if (in_acc && cvt_last) begin
          state_q     <= cdp_pkg::FLUSH;
          flush_cnt_q <= half_win;  // h empty shifts drain the tail
        end
      end
      default: begin
        if (flush_step) begin
          flush_cnt_q <= flush_cnt_q - 3'd1;
          if (flush_done) begin
            state_q     <= cdp_pkg::RUN;
            grp_start_q <= 1'b1;
          end
        end
      end
    endcase
  end
end

always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
  if (!nvdla_core_rstn) begin
    sum_valid <= 1'b0;
    sum_last  <= 1'b0;
  end else if (shift_en) begin
    sum_valid <= emit;
    sum_last  <= flush_done;  // last flush step centres the last channel
  end else if (sum_ready) begin
    sum_valid <= 1'b0;
  end
end

always_ff @(posedge nvdla_core_clk) begin
  if (shift_en) sq_q <= sq_nxt;
  if (shift_en && emit) sum_data <= win_sum;
end

// flush ends when the last channel reaches the centre with no newer slot filled
a_flush_end: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
  flush_done |-> (emit && ((mask_nxt & ~({WIN_MAX{1'b1}} << half_win)) == '0)));

endmodule

// File: hdl/cdp_lut.sv
// coefficient table
// sum >> index_select, clamped to last entry, registered lookup, clamp counter

`timescale 1ns/1ps

module cdp_lut #(
  parameter int LUT_ADDR_W = 6
) (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  input  logic                  lut_wr_en,
  input  logic [LUT_ADDR_W-1:0] lut_wr_addr,
  input  cdp_pkg::coef_t        lut_wr_data,
  input  cdp_pkg::shift_t       lut_index_select,
  input  logic                  sum_valid,
  output logic                  sum_ready,
  input  cdp_pkg::sum_t         sum_data,
  input  logic                  sum_last,
  output logic                  coef_valid,
  input  logic                  coef_ready,
  output cdp_pkg::coef_t        coef_data,
  output cdp_pkg::acc_t         perf_lut_oflow
);

localparam int LUT_DEPTH = 1 << LUT_ADDR_W;

cdp_pkg::coef_t        lut_mem [LUT_DEPTH];
cdp_pkg::sum_t         sum_shifted;
logic [LUT_ADDR_W-1:0] lut_idx;
logic                  idx_clamp;
logic                  sum_acc;

assign sum_ready   = !coef_valid || coef_ready;
assign sum_acc     = sum_valid && sum_ready;
assign sum_shifted = sum_data >> lut_index_select;
assign idx_clamp   = (sum_shifted >> LUT_ADDR_W) != '0;   // past the table end
assign lut_idx     = idx_clamp ? '1 : sum_shifted[LUT_ADDR_W-1:0];

//////////////////////////////////////////////////
// table with its register write port
always_ff @(posedge nvdla_core_clk) begin
  if (lut_wr_en) lut_mem[lut_wr_addr] <= lut_wr_data;
end

always_ff @(posedge nvdla_core_clk) begin
  if (sum_acc) coef_data <= lut_mem[lut_idx];
end

always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
  if (!nvdla_core_rstn) begin
    coef_valid     <= 1'b0;
    perf_lut_oflow <= '0;
  end else begin
    if (sum_acc) begin
      coef_valid <= 1'b1;
    end else if (coef_ready) begin
      coef_valid <= 1'b0;
    end
    if (sum_acc && idx_clamp) perf_lut_oflow <= perf_lut_oflow + 32'd1;  // wraps
  end
end

// sqsum holds sum and group marker while stalled
a_sum_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
  (sum_valid && !sum_ready) |=> (sum_valid && $stable(sum_data) && $stable(sum_last)));

endmodule

// File: hdl/cdp_sync_fifo.sv
// delay FIFO for converted values
// holds each value until its coefficient reaches the multiplier

`timescale 1ns/1ps

module cdp_sync_fifo #(
  parameter int FIFO_ADDR_W = 4
) (
  input  logic           nvdla_core_clk,
  input  logic           nvdla_core_rstn,
  input  logic           fifo_in_valid,
  output logic           fifo_in_ready,
  input  cdp_pkg::data_t cvt_data,
  output logic           dly_valid,
  input  logic           dly_ready,
  output cdp_pkg::data_t dly_data
);

localparam int DEPTH = 1 << FIFO_ADDR_W;

cdp_pkg::data_t     fifo_mem [DEPTH];
logic [FIFO_ADDR_W:0] wr_ptr_q;   // msb is the wrap bit
logic [FIFO_ADDR_W:0] rd_ptr_q;
logic               full;
logic               empty;
logic               push;
logic               pop;

assign empty = wr_ptr_q == rd_ptr_q;
assign full  = (wr_ptr_q[FIFO_ADDR_W] != rd_ptr_q[FIFO_ADDR_W]) &&
               (wr_ptr_q[FIFO_ADDR_W-1:0] == rd_ptr_q[FIFO_ADDR_W-1:0]);

assign fifo_in_ready = !full;
assign dly_valid     = !empty;
assign push          = fifo_in_valid && fifo_in_ready;
assign pop           = dly_valid && dly_ready;
assign dly_data      = fifo_mem[rd_ptr_q[FIFO_ADDR_W-1:0]];  // head, read async

always_ff @(posedge nvdla_core_clk) begin
  if (push) fifo_mem[wr_ptr_q[FIFO_ADDR_W-1:0]] <= cvt_data;
end

always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
  if (!nvdla_core_rstn) begin
    wr_ptr_q <= '0;
    rd_ptr_q <= '0;
  end else begin
    if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
    if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
  end
end

// fork and joiner must respect full and empty
a_fifo_bounds: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
  !(fifo_in_valid && full) && !(dly_ready && empty));

endmodule

// File: hdl/cdp_mul_out.sv
// combine and output conversion
// value * coef >>> shift + offset, saturated to 8 bits, saturation counter

`timescale 1ns/1ps

module cdp_mul_out (
  input  logic            nvdla_core_clk,
  input  logic            nvdla_core_rstn,
  input  logic            dly_valid,
  output logic            dly_ready,
  input  cdp_pkg::data_t  dly_data,
  input  logic            coef_valid,
  output logic            coef_ready,
  input  cdp_pkg::coef_t  coef_data,
  input  cdp_pkg::shift_t datout_scale_shift,
  input  cdp_pkg::acc_t   datout_offset,
  output logic            out_valid,
  input  logic            out_ready,
  output cdp_pkg::data_t  out_data,
  output cdp_pkg::acc_t   out_saturation
);

cdp_pkg::prod_t mul_prod;
cdp_pkg::prod_t mul_shift;
cdp_pkg::wide_t out_sum;
cdp_pkg::data_t out_nxt;
logic           out_sat;
logic           take;

// join, both sides move together
assign take       = dly_valid && coef_valid && (!out_valid || out_ready);
assign dly_ready  = take;
assign coef_ready = take;

assign mul_prod  = cdp_pkg::prod_t'(dly_data) * cdp_pkg::prod_t'(coef_data);  // coef zero-ext
assign mul_shift = mul_prod >>> datout_scale_shift;
assign out_sum   = cdp_pkg::wide_t'(mul_shift) + cdp_pkg::wide_t'($signed(datout_offset));
assign out_nxt   = cdp_pkg::sat_data(out_sum);
assign out_sat   = cdp_pkg::wide_t'(out_nxt) != out_sum;  // clipped if it changed

always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
  if (!nvdla_core_rstn) begin
    out_valid      <= 1'b0;
    out_saturation <= '0;
  end else begin
    if (take) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
    if (take && out_sat) out_saturation <= out_saturation + 32'd1;
  end
end

always_ff @(posedge nvdla_core_clk) begin
  if (take) out_data <= out_nxt;
end

endmodule

// File: hdl/cdp_dp.sv
// cross-channel normalization datapath, top level
// forks converted data into the coefficient path and the delay FIFO

`timescale 1ns/1ps

module cdp_dp #(
  parameter int LUT_ADDR_W  = 6,   // 64-entry table
  parameter int FIFO_ADDR_W = 4    // 16 values in flight
) (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  // input stream
  input  logic                  in_valid,
  output logic                  in_ready,
  input  cdp_pkg::data_t        in_data,
  input  logic                  in_last,
  // output stream
  output logic                  out_valid,
  input  logic                  out_ready,
  output cdp_pkg::data_t        out_data,
  // table writes
  input  logic                  lut_wr_en,
  input  logic [LUT_ADDR_W-1:0] lut_wr_addr,
  input  cdp_pkg::coef_t        lut_wr_data,
  // config levels
  input  cdp_pkg::data_t        datin_offset,
  input  cdp_pkg::scale_t       datin_scale,
  input  cdp_pkg::shift_t       datin_shifter,
  input  cdp_pkg::win_t         normalz_len,
  input  cdp_pkg::shift_t       lut_index_select,
  input  cdp_pkg::shift_t       datout_scale_shift,
  input  cdp_pkg::acc_t         datout_offset,
  // perf counters
  output cdp_pkg::acc_t         perf_lut_oflow,
  output cdp_pkg::acc_t         out_saturation
);

logic           cvt_valid;
logic           cvt_ready;
cdp_pkg::data_t cvt_data;
logic           cvt_last;
logic           sq_in_valid;
logic           sq_in_ready;
logic           fifo_in_valid;
logic           fifo_in_ready;
logic           sum_valid;
logic           sum_ready;
cdp_pkg::sum_t  sum_data;
logic           sum_last;
logic           coef_valid;
logic           coef_ready;
cdp_pkg::coef_t coef_data;
logic           dly_valid;
logic           dly_ready;
cdp_pkg::data_t dly_data;

//////////////////////////////////////////////////
// fork, both branches take the value in the same cycle
assign cvt_ready     = sq_in_ready && fifo_in_ready;
assign sq_in_valid   = cvt_valid && cvt_ready;
assign fifo_in_valid = cvt_valid && cvt_ready;

// stage ports share names with the nets above
cdp_cvt_in u_cvt_in (.*);

cdp_sqsum u_sqsum (.*);                              // coefficient path

cdp_lut #(.LUT_ADDR_W(LUT_ADDR_W)) u_lut (.*);

cdp_sync_fifo #(.FIFO_ADDR_W(FIFO_ADDR_W)) u_fifo (.*);  // delay path

cdp_mul_out u_mul_out (.*);                          // join and output convert

endmodule

// File: sim/cdp_dp_tb.sv
// testbench for the cross-channel normalization datapath
// per-group reference model, random gaps and back-pressure, in-order compare

`timescale 1ns/1ps

module cdp_dp_tb;

localparam int CLK_PERIOD  = 8;
localparam int SEED        = 13;
localparam int MAX_LEN     = 12;     // longest group sent
localparam int GROUPS      = 6;      // groups per phase
localparam int N_PHASES    = 9;
localparam int LUT_LAST    = 63;
// generous per-value budget covers gaps, stalls and flush
localparam int CYCLE_LIMIT = N_PHASES * (GROUPS * MAX_LEN * 40 + 200) + 20;

logic            nvdla_core_clk = 1'b0;
logic            nvdla_core_rstn;
logic            in_valid;
logic            in_ready;
cdp_pkg::data_t  in_data;
logic            in_last;
logic            out_valid;
logic            out_ready;
cdp_pkg::data_t  out_data;
logic            lut_wr_en;
logic [5:0]      lut_wr_addr;
cdp_pkg::coef_t  lut_wr_data;
cdp_pkg::data_t  datin_offset;
cdp_pkg::scale_t datin_scale;
cdp_pkg::shift_t datin_shifter;
cdp_pkg::win_t   normalz_len;
cdp_pkg::shift_t lut_index_select;
cdp_pkg::shift_t datout_scale_shift;
cdp_pkg::acc_t   datout_offset;
cdp_pkg::acc_t   perf_lut_oflow;
cdp_pkg::acc_t   out_saturation;

int     lut_ref [64];       // mirror of the coefficient table
int     grp_in  [MAX_LEN];  // raw inputs of the current group
int     exp_q   [$];        // expected outputs in input order
int     exp_oflow;
int     exp_sat;
int     cfg_win;
int     cfg_in_off;
int     cfg_in_scale;
int     cfg_in_shift;
int     cfg_idx_sel;
int     cfg_out_shift;
int     cfg_out_off;
integer seed;
integer stall_seed;          // own stream for out_ready
int     gap_pct;
int     stall_pct;
int     err_count;
int     cycle_cnt;
int     exp_val;

cdp_dp #(.LUT_ADDR_W(6), .FIFO_ADDR_W(4)) uut (.*);

initial begin
  forever #(CLK_PERIOD / 2) nvdla_core_clk = ~nvdla_core_clk;
end

//////////////////////////////////////////////////
// reference model

function automatic int clip8(input longint v);
  if (v > 127) return 127;
  if (v < -128) return -128;
  return int'(v);
endfunction

function automatic int convert_in(input int x);
  longint v;
  v = longint'(x - cfg_in_off) * longint'(cfg_in_scale);
  v = v >>> cfg_in_shift;  // floor division by 2^shift
  return clip8(v);
endfunction

// clipped centred window, clamped index, output conversion
function automatic void expect_group(input int len);
  int     cv [MAX_LEN];
  int     h;
  int     lo;
  int     hi;
  int     idx;
  longint win_sum;
  longint y;
  h = cfg_win + 1;
  for (int c = 0; c < len; c++) cv[c] = convert_in(grp_in[c]);
  for (int c = 0; c < len; c++) begin
    lo = (c - h < 0) ? 0 : c - h;              // clip at group start
    hi = (c + h > len - 1) ? len - 1 : c + h;  // and at group end
    win_sum = 0;
    for (int j = lo; j <= hi; j++) win_sum += longint'(cv[j] * cv[j]);
    idx = int'(win_sum >> cfg_idx_sel);
    if (idx > LUT_LAST) begin
      idx = LUT_LAST;
      exp_oflow++;
    end
    y = (longint'(cv[c]) * longint'(lut_ref[idx])) >>> cfg_out_shift;
    y = y + longint'(cfg_out_off);
    if (longint'(clip8(y)) != y) exp_sat++;
    exp_q.push_back(clip8(y));
  end
endfunction

//////////////////////////////////////////////////
// checks and stimulus

task automatic check_value(input string what, input logic signed [63:0] got,
                           input logic signed [63:0] exp);
  if (got !== exp) begin
    err_count++;
    $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first mismatch");
  end
endtask

task automatic set_config(input int win, input int in_off, input int in_scale,
                          input int in_shift, input int idx_sel, input int out_shift,
                          input int out_off);
  cfg_win            = win;
  cfg_in_off         = in_off;
  cfg_in_scale       = in_scale;
  cfg_in_shift       = in_shift;
  cfg_idx_sel        = idx_sel;
  cfg_out_shift      = out_shift;
  cfg_out_off        = out_off;
  normalz_len        = cdp_pkg::win_t'(win);
  datin_offset       = cdp_pkg::data_t'(in_off);
  datin_scale        = cdp_pkg::scale_t'(in_scale);
  datin_shifter      = cdp_pkg::shift_t'(in_shift);
  lut_index_select   = cdp_pkg::shift_t'(idx_sel);
  datout_scale_shift = cdp_pkg::shift_t'(out_shift);
  datout_offset      = cdp_pkg::acc_t'(out_off);
endtask

// one strobe per entry with random coefficients of coef_bits bits
task automatic load_table(input int coef_bits);
  logic [31:0] raw;
  for (int a = 0; a < 64; a++) begin
    raw         = $random(seed);
    lut_ref[a]  = int'(raw[15:0] >> (16 - coef_bits));
    lut_wr_en   = 1'b1;
    lut_wr_addr = 6'(a);
    lut_wr_data = cdp_pkg::coef_t'(lut_ref[a]);
    @(negedge nvdla_core_clk);
  end
  lut_wr_en = 1'b0;
endtask

task automatic send_value(input int d, input logic last);
  while (int'({$random(seed)} % 100) < gap_pct) @(negedge nvdla_core_clk);  // idle beat
  in_valid = 1'b1;
  in_data  = cdp_pkg::data_t'(d);
  in_last  = last;
  @(posedge nvdla_core_clk);
  while (!in_ready) @(posedge nvdla_core_clk);  // held until taken
  @(negedge nvdla_core_clk);
  in_valid = 1'b0;
endtask

// first group of every phase has one channel
task automatic run_groups(input int n_groups, input bit narrow);
  logic [31:0] raw;
  int          len;
  for (int g = 0; g < n_groups; g++) begin
    len = (g == 0) ? 1 : 1 + int'({$random(seed)} % MAX_LEN);
    for (int c = 0; c < len; c++) begin
      raw       = $random(seed);
      grp_in[c] = narrow ? int'(raw[4:0]) - 16 : int'($signed(raw[7:0]));
    end
    expect_group(len);
    for (int c = 0; c < len; c++) send_value(grp_in[c], c == len - 1);
  end
endtask

task automatic drain();
  while (exp_q.size() != 0) @(negedge nvdla_core_clk);
  check_value("perf_lut_oflow", perf_lut_oflow, exp_oflow);
  check_value("out_saturation", out_saturation, exp_sat);
  repeat (4) @(negedge nvdla_core_clk);
endtask

//////////////////////////////////////////////////
// compare, back-pressure, timeout

always @(posedge nvdla_core_clk) begin
  if (nvdla_core_rstn && out_valid && out_ready) begin
    if (exp_q.size() == 0) begin
      $display("output %0d at %0t arrived with no value left to expect", out_data, $time);
      $display("TESTS FAILED");
      $fatal(1, "extra output");
    end else begin
      exp_val = exp_q.pop_front();
      check_value("out_data", out_data, exp_val);
    end
  end
end

always @(negedge nvdla_core_clk) begin
  out_ready = int'({$random(stall_seed)} % 100) >= stall_pct;
end

always @(posedge nvdla_core_clk) begin
  cycle_cnt++;
  if (cycle_cnt >= CYCLE_LIMIT) begin
    $display("timeout: run still busy after %0d cycles, %0d outputs missing",
             cycle_cnt, exp_q.size());
    $display("TESTS FAILED");
    $fatal(1, "hung run");
  end
end

//////////////////////////////////////////////////
// test sequence

initial begin
  seed            = SEED;
  stall_seed      = SEED + 1;
  gap_pct         = 20;
  stall_pct       = 25;
  err_count       = 0;
  cycle_cnt       = 0;
  exp_oflow       = 0;
  exp_sat         = 0;
  nvdla_core_rstn = 1'b0;
  in_valid        = 1'b0;
  in_data         = '0;
  in_last         = 1'b0;
  out_ready       = 1'b0;
  lut_wr_en       = 1'b0;
  lut_wr_addr     = '0;
  lut_wr_data     = '0;
  set_config(0, 0, 1, 0, 5, 9, 0);
  repeat (10) @(posedge nvdla_core_clk);
  @(negedge nvdla_core_clk);
  nvdla_core_rstn = 1'b1;
  @(negedge nvdla_core_clk);
  check_value("in_ready after reset", in_ready, 1);
  check_value("out_valid after reset", out_valid, 0);
  check_value("perf_lut_oflow after reset", perf_lut_oflow, 0);
  check_value("out_saturation after reset", out_saturation, 0);

  for (int w = 0; w < 4; w++) begin  // 3, 5, 7, 9 channel windows
    set_config(w, 0, 1, 0, 5, 9, 0);
    load_table(12);
    run_groups(GROUPS, 1'b1);
    drain();
  end

  set_config(2, -20, -700, 6, 10, 10, 0);  // input conversion clips often
  load_table(12);
  run_groups(GROUPS, 1'b0);
  drain();

  set_config(1, 0, 1, 0, 0, 10, 0);  // nearly every index past the table end
  load_table(12);
  run_groups(GROUPS, 1'b0);
  drain();

  set_config(1, 0, 1, 0, 4, 4, 100);  // output clips high
  load_table(16);
  run_groups(GROUPS, 1'b1);
  drain();
  set_config(0, 0, 1, 0, 4, 8, -200);  // and low
  load_table(16);
  run_groups(GROUPS, 1'b1);
  drain();

  gap_pct   = 70;  // heavy gaps and stalls
  stall_pct = 75;
  set_config(3, 5, 3, 2, 8, 8, 0);
  load_table(12);
  run_groups(GROUPS, 1'b0);
  drain();

  if (err_count == 0 && exp_q.size() == 0) begin
    $display("TESTS PASSED");
    $finish;
  end else begin
    $display("TESTS FAILED");
    $fatal(1, "run ended with %0d errors", err_count);
  end
end

endmodule

// File: filelist.f
hdl/cdp_pkg.sv
hdl/cdp_cvt_in.sv
hdl/cdp_sqsum.sv
hdl/cdp_lut.sv
hdl/cdp_sync_fifo.sv
hdl/cdp_mul_out.sv
hdl/cdp_dp.sv
sim/cdp_dp_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = cdp_dp_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
